// File: logic/rv_pkg.sv
// Shared definitions for the RV32I decode and execute slice
// Widths, opcode and funct3 codes, CSR addresses and ALU codes
// Decoder control, CSR request and writeback records
`default_nettype none

package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [1:0]      res_sel_t;
  typedef logic [1:0]      csr_op_t;

  // Major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_IMM    = 7'b0010011;
  localparam opcode_t OPC_REG    = 7'b0110011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // ALU funct3, shared by OP and OP-IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // CSR funct3 under SYSTEM
  localparam funct3_t F3_CSRRW  = 3'b001;
  localparam funct3_t F3_CSRRS  = 3'b010;
  localparam funct3_t F3_CSRRC  = 3'b011;
  localparam funct3_t F3_CSRRWI = 3'b101;
  localparam funct3_t F3_CSRRSI = 3'b110;
  localparam funct3_t F3_CSRRCI = 3'b111;

  // Implemented machine CSRs
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // Operand and result selects
  localparam logic     A_SEL_RS1 = 1'b0;
  localparam logic     A_SEL_PC  = 1'b1;
  localparam logic     B_SEL_RS2 = 1'b0;
  localparam logic     B_SEL_IMM = 1'b1;
  localparam res_sel_t RES_ALU   = 2'd0;
  localparam res_sel_t RES_IMM   = 2'd1;
  localparam res_sel_t RES_CSR   = 2'd2;

  localparam csr_op_t CSR_OP_NONE  = 2'd0;
  localparam csr_op_t CSR_OP_SWAP  = 2'd1;
  localparam csr_op_t CSR_OP_SET   = 2'd2;
  localparam csr_op_t CSR_OP_CLEAR = 2'd3;

  typedef struct packed {
    alu_op_t    alu_op;
    logic       a_sel;
    logic       b_sel;
    res_sel_t   res_sel;
    xlen_t      imm;
    reg_idx_t   rd;
    logic       reg_wen;
    csr_op_t    csr_op;
    logic       csr_imm;
    logic [4:0] zimm;
    csr_addr_t  csr_addr;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic      en;
    csr_op_t   op;
    csr_addr_t addr;
    xlen_t     wdata;
  } csr_req_t;

  typedef struct packed {
    logic     valid;
    logic     illegal;
    reg_idx_t rd;
    xlen_t    data;
  } wb_t;

endpackage

`default_nettype wire

// File: logic/instr_decoder.sv
// Instruction decoder for the RV32I subset
// Immediate slicing, ALU op mapping, operand and result selects
// CSR operation decode and illegal instruction detection
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_pkg::*; (
  input  instr_t    instr_i,
  output dec_ctrl_t ctrl_o,
  output reg_idx_t  rs1_o,
  output reg_idx_t  rs2_o
);

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  logic       alt_bit;
  logic       is_shift;
  logic       funct7_ok;
  alu_op_t    alu_op;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_sh;

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  // Bit 30 selects SUB and SRA
  assign alt_bit = instr_i[30];

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];

  // I, U and shift-amount immediates
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_sh = {27'b0, instr_i[24:20]};

  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);

  // Only the alternate bit may be set, and only for add/sub and right shift
  assign funct7_ok = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));

  always_comb begin
    alu_op = ALU_ADD;
    if (opcode == OPC_IMM || opcode == OPC_REG) begin
      case (funct3)
        F3_ADD:  alu_op = (opcode == OPC_REG && alt_bit) ? ALU_SUB : ALU_ADD;
        F3_SLL:  alu_op = ALU_SLL;
        F3_SLT:  alu_op = ALU_SLT;
        F3_SLTU: alu_op = ALU_SLTU;
        F3_XOR:  alu_op = ALU_XOR;
        F3_SR:   alu_op = alt_bit ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op = ALU_OR;
        F3_AND:  alu_op = ALU_AND;
      endcase
    end
  end

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.alu_op   = alu_op;
    ctrl_o.a_sel    = A_SEL_RS1;
    ctrl_o.b_sel    = B_SEL_IMM;
    ctrl_o.res_sel  = RES_ALU;
    ctrl_o.imm      = imm_i;
    ctrl_o.rd       = instr_i[11:7];
    ctrl_o.csr_op   = CSR_OP_NONE;
    ctrl_o.zimm     = instr_i[19:15];
    ctrl_o.csr_addr = instr_i[31:20];

    case (opcode)
      OPC_LUI: begin
        ctrl_o.res_sel = RES_IMM;
        ctrl_o.imm     = imm_u;
        ctrl_o.reg_wen = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl_o.a_sel   = A_SEL_PC;
        ctrl_o.imm     = imm_u;
        ctrl_o.reg_wen = 1'b1;
      end
      OPC_IMM: begin
        ctrl_o.reg_wen = 1'b1;
        // Shift immediates carry funct7 in the upper bits
        if (is_shift) begin
          ctrl_o.imm     = imm_sh;
          ctrl_o.illegal = ~funct7_ok;
        end
      end
      OPC_REG: begin
        ctrl_o.b_sel   = B_SEL_RS2;
        ctrl_o.reg_wen = 1'b1;
        ctrl_o.illegal = ~funct7_ok;
      end
      OPC_SYSTEM: begin
        ctrl_o.res_sel = RES_CSR;
        ctrl_o.reg_wen = 1'b1;
        ctrl_o.csr_imm = funct3[2];
        case (funct3)
          F3_CSRRW, F3_CSRRWI: ctrl_o.csr_op = CSR_OP_SWAP;
          F3_CSRRS, F3_CSRRSI: ctrl_o.csr_op = CSR_OP_SET;
          F3_CSRRC, F3_CSRRCI: ctrl_o.csr_op = CSR_OP_CLEAR;
          default: begin
            // ECALL, EBREAK, MRET and the reserved funct3
            ctrl_o.reg_wen = 1'b0;
            ctrl_o.illegal = 1'b1;
          end
        endcase
      end
      default: begin
        ctrl_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/int_reg_file.sv
// Integer register file, 32 x 32 bits
// Two combinational read ports, one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module int_reg_file import rv_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output xlen_t    rd1_o,
  output xlen_t    rd2_o,
  input  logic     we_i,
  input  reg_idx_t wa_i,
  input  xlen_t    wd_i
);

  // No storage behind x0
  xlen_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (wa_i != '0)) begin
      regs_q[wa_i] <= wd_i;
    end
  end

  assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// File: logic/csr_file.sv
// Machine CSR file: mscratch, mtvec, mepc, mcause
// Address decode with hit flag, old-value read
// Swap, set and clear updates
`timescale 1ns/1ps
`default_nettype none

module csr_file import rv_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  csr_req_t req_i,
  output xlen_t    rdata_o,
  output logic     hit_o
);

  xlen_t mscratch_q;
  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t old_val;
  xlen_t new_val;

  always_comb begin
    hit_o = 1'b1;
    case (req_i.addr)
      CSR_MSCRATCH: old_val = mscratch_q;
      CSR_MTVEC:    old_val = mtvec_q;
      CSR_MEPC:     old_val = mepc_q;
      CSR_MCAUSE:   old_val = mcause_q;
      default: begin
        hit_o   = 1'b0;
        old_val = '0;
      end
    endcase
  end

  assign rdata_o = old_val;

  always_comb begin
    case (req_i.op)
      CSR_OP_SWAP:  new_val = req_i.wdata;
      CSR_OP_SET:   new_val = old_val | req_i.wdata;
      CSR_OP_CLEAR: new_val = old_val & ~req_i.wdata;
      default:      new_val = old_val;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (req_i.en && hit_o) begin
      case (req_i.addr)
        CSR_MSCRATCH: mscratch_q <= new_val;
        CSR_MTVEC:    mtvec_q    <= new_val;
        CSR_MEPC:     mepc_q     <= new_val;
        CSR_MCAUSE:   mcause_q   <= new_val;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
// Execute unit: operand select, ALU and result select
// Illegal combining, register and CSR write gating
// Registered writeback record
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  dec_ctrl_t ctrl_i,
  input  xlen_t     pc_i,
  input  xlen_t     rs1_val_i,
  input  xlen_t     rs2_val_i,
  input  xlen_t     csr_rdata_i,
  input  logic      csr_hit_i,
  output csr_req_t  csr_req_o,
  output logic      rf_we_o,
  output reg_idx_t  rf_wa_o,
  output xlen_t     rf_wd_o,
  output wb_t       wb_o
);

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_res;
  xlen_t      result;
  logic       is_csr;
  logic       illegal;
  logic       valid_q;
  logic       illegal_q;
  reg_idx_t   rd_q;
  xlen_t      data_q;

  assign op_a  = (ctrl_i.a_sel == A_SEL_PC) ? pc_i : rs1_val_i;
  assign op_b  = (ctrl_i.b_sel == B_SEL_IMM) ? ctrl_i.imm : rs2_val_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.res_sel)
      RES_IMM: result = ctrl_i.imm;
      RES_CSR: result = csr_rdata_i;
      default: result = alu_res;
    endcase
  end

  // A CSR access to an unimplemented address is illegal too
  assign is_csr  = (ctrl_i.csr_op != CSR_OP_NONE);
  assign illegal = ctrl_i.illegal | (is_csr & ~csr_hit_i);

  always_comb begin
    csr_req_o.en    = valid_i & ~ctrl_i.illegal & is_csr;
    csr_req_o.op    = ctrl_i.csr_op;
    csr_req_o.addr  = ctrl_i.csr_addr;
    csr_req_o.wdata = ctrl_i.csr_imm ? {27'b0, ctrl_i.zimm} : rs1_val_i;
  end

  assign rf_we_o = valid_i & ~illegal & ctrl_i.reg_wen;
  assign rf_wa_o = ctrl_i.rd;
  assign rf_wd_o = result;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= valid_i;
      illegal_q <= valid_i & illegal;
    end
  end

  // Illegal instructions report rd and data as zero
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rd_q   <= illegal ? '0 : ctrl_i.rd;
      data_q <= illegal ? '0 : result;
    end
  end

  always_comb begin
    wb_o.valid   = valid_q;
    wb_o.illegal = illegal_q;
    wb_o.rd      = rd_q;
    wb_o.data    = data_q;
  end

endmodule

`default_nettype wire

// File: logic/exec_core.sv
// Top level of the decode and execute slice
// Decoder, register file, CSR file and execute unit
`timescale 1ns/1ps
`default_nettype none

module exec_core import rv_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   instr_valid_i,
  input  instr_t instr_i,
  input  xlen_t  pc_i,
  output wb_t    wb_o
);

  dec_ctrl_t ctrl;
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  csr_req_t  csr_req;
  xlen_t     csr_rdata;
  logic      csr_hit;
  logic      rf_we;
  reg_idx_t  rf_wa;
  xlen_t     rf_wd;

  instr_decoder u_decoder (
    .instr_i (instr_i),
    .ctrl_o  (ctrl),
    .rs1_o   (rs1_idx),
    .rs2_o   (rs2_idx)
  );

  int_reg_file u_reg_file (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rs1_i   (rs1_idx),
    .rs2_i   (rs2_idx),
    .rd1_o   (rs1_val),
    .rd2_o   (rs2_val),
    .we_i    (rf_we),
    .wa_i    (rf_wa),
    .wd_i    (rf_wd)
  );

  // Configuration block steered by the execute unit
  csr_file u_csr_file (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (csr_req),
    .rdata_o (csr_rdata),
    .hit_o   (csr_hit)
  );

  exec_unit u_exec_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (instr_valid_i),
    .ctrl_i      (ctrl),
    .pc_i        (pc_i),
    .rs1_val_i   (rs1_val),
    .rs2_val_i   (rs2_val),
    .csr_rdata_i (csr_rdata),
    .csr_hit_i   (csr_hit),
    .csr_req_o   (csr_req),
    .rf_we_o     (rf_we),
    .rf_wa_o     (rf_wa),
    .rf_wd_o     (rf_wd),
    .wb_o        (wb_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_exec_core.sv
// Testbench for the RV32I decode and execute slice
// Clock, reset, directed and random instruction stimulus
// Reference model with register and CSR state, writeback compare
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core import rv_pkg::*; ();

  logic        clk = 1'b0;
  logic        rst_n;
  logic        instr_valid;
  instr_t      instr;
  xlen_t       pc;
  wb_t         wb;
  logic [31:0] rng = 32'hf306;
  xlen_t       pc_next;
  xlen_t       model_rf [32];
  xlen_t       model_csr [4];
  wb_t         exp_q [$];

  exec_core u_exec_core (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .wb_o          (wb)
  );

  // Clock starts low, first edge is the rising one at 20 ns
  initial begin
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic instr_t enc_i(input opcode_t opc, input funct3_t f3, input reg_idx_t rd,
                                   input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input funct3_t f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic instr_t enc_u(input opcode_t opc, input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // Two of eight picks are unimplemented addresses
  function automatic csr_addr_t pick_csr(input logic [2:0] sel);
    case (sel)
      3'd0, 3'd4: return CSR_MSCRATCH;
      3'd1, 3'd5: return CSR_MTVEC;
      3'd2:       return CSR_MEPC;
      3'd3:       return CSR_MCAUSE;
      3'd6:       return 12'h300;
      default:    return 12'hc00;
    endcase
  endfunction

  function automatic int csr_slot(input csr_addr_t addr);
    case (addr)
      CSR_MSCRATCH: return 0;
      CSR_MTVEC:    return 1;
      CSR_MEPC:     return 2;
      CSR_MCAUSE:   return 3;
      default:      return -1;
    endcase
  endfunction

  function automatic xlen_t alu_ref(input funct3_t f3, input logic alt, input xlen_t a,
                                    input xlen_t b);
    case (f3)
      F3_ADD:  return alt ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return {31'b0, ($signed(a) < $signed(b))};
      F3_SLTU: return {31'b0, (a < b)};
      F3_XOR:  return a ^ b;
      F3_SR:   return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // Expected writeback record, and the model state moves on
  function automatic wb_t ref_exec(input instr_t ins, input xlen_t ins_pc);
    opcode_t    opc;
    funct3_t    f3;
    logic [6:0] f7;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      res;
    xlen_t      wdata;
    xlen_t      old_val;
    logic       bad;
    int         slot;
    wb_t        rec;
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    rd    = ins[11:7];
    rs1   = ins[19:15];
    rs2   = ins[24:20];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'b0};
    bad   = 1'b0;
    res   = '0;
    case (opc)
      OPC_LUI:   res = imm_u;
      OPC_AUIPC: res = ins_pc + imm_u;
      OPC_IMM: begin
        if (f3 == F3_SLL || f3 == F3_SR) begin
          bad = !(f7 == 7'h00 || (f7 == 7'h20 && f3 == F3_SR));
        end
        res = alu_ref(f3, (f3 == F3_SR) && ins[30], model_rf[rs1], imm_i);
      end
      OPC_REG: begin
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == F3_ADD || f3 == F3_SR)));
        res = alu_ref(f3, ins[30], model_rf[rs1], model_rf[rs2]);
      end
      OPC_SYSTEM: begin
        slot = csr_slot(ins[31:20]);
        if (f3[1:0] == 2'b00 || slot < 0) begin
          bad = 1'b1;
        end else begin
          old_val = model_csr[slot];
          // Immediate forms use the rs1 field as zimm
          wdata = f3[2] ? {27'b0, rs1} : model_rf[rs1];
          case (f3[1:0])
            2'b01:   model_csr[slot] = wdata;
            2'b10:   model_csr[slot] = old_val | wdata;
            default: model_csr[slot] = old_val & ~wdata;
          endcase
          res = old_val;
        end
      end
      default: bad = 1'b1;
    endcase
    rec.valid   = 1'b1;
    rec.illegal = bad;
    rec.rd      = bad ? '0 : rd;
    rec.data    = bad ? '0 : res;
    if (!bad && rd != '0) begin
      model_rf[rd] = res;
    end
    return rec;
  endfunction

  function automatic instr_t gen_instr();
    logic [31:0] r;
    logic [31:0] s;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    funct3_t     f3;
    logic [6:0]  f7;
    instr_t      ins;
    r   = next_rand();
    s   = next_rand();
    // Few registers, so dependencies come often
    rd  = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    f3  = r[11:9];
    case (s[6:5])
      2'd0:    f7 = 7'h00;
      2'd3:    f7 = 7'h01;
      default: f7 = 7'h20;
    endcase
    case (r[15:12])
      4'd0: ins = enc_u(OPC_LUI, rd, s[31:12]);
      4'd1: ins = enc_u(OPC_AUIPC, rd, s[31:12]);
      4'd2, 4'd3, 4'd4, 4'd5: begin
        if (f3 == F3_SLL || f3 == F3_SR) begin
          ins = enc_i(OPC_IMM, f3, rd, rs1, {f7, s[4:0]});
        end else begin
          ins = enc_i(OPC_IMM, f3, rd, rs1, s[31:20]);
        end
      end
      4'd6, 4'd7, 4'd8, 4'd9: ins = enc_r(f7, rs2, rs1, f3, rd);
      4'd10, 4'd11, 4'd12: begin
        f3  = {s[4], (s[6:5] == 2'b00) ? 2'b01 : s[6:5]};
        ins = enc_i(OPC_SYSTEM, f3, rd, s[4] ? s[11:7] : rs1, pick_csr(s[2:0]));
      end
      4'd13: ins = enc_i(OPC_SYSTEM, {s[0], 2'b00}, rd, rs1, pick_csr(s[3:1]));
      4'd14: begin
        // Load, store, branch and JAL opcodes
        case (s[1:0])
          2'd0:    ins = enc_i(7'b0000011, f3, rd, rs1, s[31:20]);
          2'd1:    ins = enc_i(7'b0100011, f3, rd, rs1, s[31:20]);
          2'd2:    ins = enc_i(7'b1100011, f3, rd, rs1, s[31:20]);
          default: ins = enc_i(7'b1101111, f3, rd, rs1, s[31:20]);
        endcase
      end
      default: ins = enc_i(OPC_SYSTEM, F3_CSRRS, rd, 5'd0, pick_csr(s[2:0]));
    endcase
    return ins;
  endfunction

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input xlen_t act, input xlen_t exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, act, exp);
      stop_run();
    end
  endtask

  // Idle records only fix valid and illegal
  task automatic check_wb(input wb_t act, input wb_t exp);
    logic bad;
    bad = (act.valid !== exp.valid) || (act.illegal !== exp.illegal);
    if (exp.valid) begin
      bad = bad || (act.rd !== exp.rd);
    end
    if (bad) begin
      $display("MISMATCH at %0t: wb_o got %h, expected %h", $time, act, exp);
      stop_run();
    end else if (exp.valid) begin
      check_data("wb_o.data", act.data, exp.data);
    end
  endtask

  task automatic issue(input logic valid, input instr_t ins, input xlen_t ins_pc);
    wb_t exp;
    @(negedge clk);
    instr_valid = valid;
    instr       = ins;
    pc          = ins_pc;
    exp         = '0;
    if (valid) begin
      exp = ref_exec(ins, ins_pc);
    end
    exp_q.push_back(exp);
  endtask

  task automatic issue_instr(input instr_t ins);
    issue(1'b1, ins, pc_next);
    pc_next = pc_next + 32'd4;
  endtask

  // Record from the previous falling edge is out just after the rising edge
  initial begin
    wb_t exp;
    forever begin
      @(posedge clk);
      #1;
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        check_wb(wb, exp);
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          wait_cycles;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    pc_next     = 32'h0000_1000;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      model_csr[i] = '0;
    end
    repeat (5) issue(1'b0, '0, '0);
    rst_n = 1'b1;
    issue(1'b0, '0, '0);

    // Write to x0 is dropped
    issue_instr(enc_i(OPC_IMM, F3_ADD, 5'd0, 5'd0, 12'd5));
    issue_instr(enc_r(7'h00, 5'd0, 5'd0, F3_ADD, 5'd1));
    issue_instr(enc_u(OPC_LUI, 5'd1, 20'h80000));
    issue_instr(enc_i(OPC_IMM, F3_SR, 5'd2, 5'd1, {7'h20, 5'd4}));
    issue_instr(enc_i(OPC_IMM, F3_SR, 5'd3, 5'd1, {7'h00, 5'd4}));
    issue_instr(enc_r(7'h00, 5'd3, 5'd1, F3_SLT, 5'd4));
    issue_instr(enc_r(7'h00, 5'd3, 5'd1, F3_SLTU, 5'd5));
    issue_instr(enc_r(7'h20, 5'd1, 5'd3, F3_ADD, 5'd6));
    issue_instr(enc_u(OPC_AUIPC, 5'd7, 20'h12345));
    issue_instr(enc_i(OPC_SYSTEM, F3_CSRRW, 5'd7, 5'd6, CSR_MSCRATCH));
    issue_instr(enc_i(OPC_SYSTEM, F3_CSRRSI, 5'd0, 5'd3, CSR_MSCRATCH));
    issue_instr(enc_i(OPC_SYSTEM, F3_CSRRCI, 5'd0, 5'd1, CSR_MSCRATCH));
    issue_instr(enc_i(OPC_SYSTEM, F3_CSRRS, 5'd7, 5'd0, CSR_MSCRATCH));

    for (int n = 0; n < 400; n++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        issue(1'b0, next_rand(), next_rand());
      end else begin
        issue_instr(gen_instr());
      end
    end

    // Read back all registers and CSRs
    for (int i = 0; i < 32; i++) begin
      issue_instr(enc_i(OPC_IMM, F3_ADD, 5'd0, reg_idx_t'(i), 12'd0));
    end
    for (int k = 0; k < 4; k++) begin
      issue_instr(enc_i(OPC_SYSTEM, F3_CSRRS, 5'd0, 5'd0, pick_csr(3'(k))));
    end
    issue(1'b0, '0, '0);

    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 10) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d expected records were never compared", exp_q.size());
      stop_run();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: all.f
logic/rv_pkg.sv
logic/instr_decoder.sv
logic/int_reg_file.sv
logic/csr_file.sv
logic/exec_unit.sv
logic/exec_core.sv
testbench/tb_exec_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_exec_core -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "All checks passed" \
  || exit 1
